/* hw/vfe_pkg.sv */
// Shared types of the vector front end. IdWidth must match the scalar core's id width.
// The instruction union assumes the RVV 1.0 layout of OP-V and vector load/store words.

package vfe_pkg;

  //////////////////////////////
  // Widths and opcodes
  //////////////////////////////

  // Instruction id handed out by the scalar core
  localparam int unsigned IdWidth = 4;

  localparam logic [6:0] OpcodeOpV     = 7'b1010111;
  localparam logic [6:0] OpcodeLoadFp  = 7'b0000111;
  localparam logic [6:0] OpcodeStoreFp = 7'b0100111;

  // OP-V categories in funct3
  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPFVV = 3'b001,
    OPMVV = 3'b010,
    OPIVI = 3'b011,
    OPIVX = 3'b100,
    OPFVF = 3'b101,
    OPMVX = 3'b110,
    OPCFG = 3'b111
  } vfe_funct3_e;

  // VWXUNARY0 group, holds vmv.x.s, vcpop.m and vfirst.m
  localparam logic [5:0] Funct6Wxunary0 = 6'b010000;

  // Element widths of vector loads and stores
  localparam logic [2:0] MemWidth8  = 3'b000;
  localparam logic [2:0] MemWidth16 = 3'b101;
  localparam logic [2:0] MemWidth32 = 3'b110;
  localparam logic [2:0] MemWidth64 = 3'b111;

  //////////////////////////////
  // Instruction views
  //////////////////////////////

  typedef struct packed {
    logic [5:0]  funct6;
    logic        vm;
    logic [4:0]  vs2;
    logic [4:0]  vs1;
    vfe_funct3_e funct3;
    logic [4:0]  vd;
    logic [6:0]  opcode;
  } vfe_arith_t;

  typedef struct packed {
    logic [2:0] nf;
    logic       mew;
    logic [1:0] mop;
    logic       vm;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] width;
    logic [4:0] vd;
    logic [6:0] opcode;
  } vfe_mem_t;

  // Same 32 bits, decoded by opcode
  typedef union packed {
    vfe_arith_t arith;
    vfe_mem_t   mem;
  } vfe_instr_u;

  //////////////////////////////
  // Port bundles
  //////////////////////////////

  typedef struct packed {
    logic               valid;
    vfe_instr_u         instr;
    logic [IdWidth-1:0] id;
  } vfe_issue_req_t;

  typedef struct packed {
    logic ready;
    logic accept;
    logic writeback;
    logic register_read;
  } vfe_issue_resp_t;

  // One-cycle strobe, kill drops all uncommitted work
  typedef struct packed {
    logic               valid;
    logic [IdWidth-1:0] id;
    logic               kill;
  } vfe_commit_t;

  typedef struct packed {
    logic accept;
    logic writeback;
    logic register_read;
  } vfe_class_t;

  typedef struct packed {
    vfe_instr_u         instr;
    logic [IdWidth-1:0] id;
  } vfe_entry_t;

  typedef struct packed {
    logic       valid;
    vfe_entry_t entry;
  } vfe_dispatch_t;

endpackage

/* hw/vfe_pre_decoder.sv */
// Purely combinational. Vector FP arithmetic (OPFVV, OPFVF) is always rejected.
// Vector loads and stores are accepted for the four integer element widths only.
`timescale 1ns/100ps

module vfe_pre_decoder import vfe_pkg::*; (
  input  vfe_instr_u instr_i,
  output vfe_class_t class_o
);

  vfe_class_t arith_class;
  vfe_class_t mem_class;
  logic       is_opv;
  logic       is_vmem;

  assign is_opv  = (instr_i.arith.opcode == OpcodeOpV);
  assign is_vmem = (instr_i.mem.opcode == OpcodeLoadFp) ||
                   (instr_i.mem.opcode == OpcodeStoreFp);

  //////////////////////////////
  // OP-V view
  //////////////////////////////

  always_comb begin
    arith_class = '0;
    case (instr_i.arith.funct3)
      OPIVV, OPIVI: begin
        arith_class.accept = 1'b1;
      end
      // Scalar operand comes from x register file
      OPIVX, OPMVX: begin
        arith_class.accept        = 1'b1;
        arith_class.register_read = 1'b1;
      end
      OPMVV: begin
        arith_class.accept = 1'b1;
        // vmv.x.s and friends return a scalar
        arith_class.writeback = (instr_i.arith.funct6 == Funct6Wxunary0);
      end
      // vsetvli, vsetivli, vsetvl write the new vl back
      OPCFG: begin
        arith_class.accept        = 1'b1;
        arith_class.writeback     = 1'b1;
        arith_class.register_read = 1'b1;
      end
      default: begin
        arith_class = '0;
      end
    endcase
  end

  //////////////////////////////
  // Load/store view
  //////////////////////////////

  always_comb begin
    mem_class = '0;
    // Other widths belong to scalar FP loads and stores
    if (instr_i.mem.width inside {MemWidth8, MemWidth16, MemWidth32, MemWidth64}) begin
      mem_class.accept        = 1'b1;
      mem_class.register_read = 1'b1;
    end
  end

  // Pick the view that matches the opcode
  always_comb begin
    if (is_opv) begin
      class_o = arith_class;
    end else if (is_vmem) begin
      class_o = mem_class;
    end else begin
      class_o = '0;
    end
  end

endmodule

/* hw/vfe_spec_buffer.sv */
// Depth must be a power of two from 2 to 16. Commits arrive in issue order.
// Kill only removes uncommitted entries; committed ones stay until popped.
`timescale 1ns/100ps

module vfe_spec_buffer import vfe_pkg::*; #(
  parameter int unsigned Depth = 4
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        push_i,
  input  vfe_entry_t  entry_i,
  input  vfe_commit_t commit_i,
  input  logic        pop_i,
  output logic        full_o,
  output vfe_entry_t  head_o,
  output logic        head_committed_o
);

  // Extra MSB tells a full ring from an empty one
  localparam int unsigned PtrWidth = $clog2(Depth);

  typedef logic [PtrWidth:0] ptr_t;

  vfe_entry_t mem_q [Depth];
  ptr_t       rd_ptr_q;
  ptr_t       cm_ptr_q;
  ptr_t       wr_ptr_q;
  logic       commit_fire;
  logic       kill_fire;
  logic       has_uncommitted;

  if (Depth < 2 || Depth > 16 || (Depth & (Depth - 1)) != 0) begin : gen_depth_check
    $error("vfe_spec_buffer: Depth must be a power of two between 2 and 16");
  end

  assign commit_fire = commit_i.valid && !commit_i.kill;
  assign kill_fire   = commit_i.valid && commit_i.kill;

  assign has_uncommitted = (cm_ptr_q != wr_ptr_q);

  assign full_o = (wr_ptr_q[PtrWidth] != rd_ptr_q[PtrWidth]) &&
                  (wr_ptr_q[PtrWidth-1:0] == rd_ptr_q[PtrWidth-1:0]);

  assign head_o           = mem_q[rd_ptr_q[PtrWidth-1:0]];
  assign head_committed_o = (rd_ptr_q != cm_ptr_q);

  //////////////////////////////
  // Pointers
  //////////////////////////////

  // Oldest entry, leaves on pop
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_ptr_q <= '0;
    end else if (pop_i) begin
      rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  // First uncommitted entry
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cm_ptr_q <= '0;
    end else if (commit_fire) begin
      cm_ptr_q <= cm_ptr_q + 1'b1;
    end
  end

  // Kill rewinds the write side to the commit point
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
    end else if (kill_fire) begin
      wr_ptr_q <= cm_ptr_q;
    end else if (push_i) begin
      wr_ptr_q <= wr_ptr_q + 1'b1;
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q[PtrWidth-1:0]] <= entry_i;
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Issue ready must already have dropped
  a_no_push_full: assert property (@(posedge clk_i) disable iff (rst_i)
    push_i |-> !full_o)
    else $error("vfe_spec_buffer: push while full");

  a_commit_pending: assert property (@(posedge clk_i) disable iff (rst_i)
    commit_fire |-> has_uncommitted)
    else $error("vfe_spec_buffer: commit with no uncommitted entry");

  // Core commits strictly in issue order
  a_commit_order: assert property (@(posedge clk_i) disable iff (rst_i)
    commit_fire && has_uncommitted |-> mem_q[cm_ptr_q[PtrWidth-1:0]].id == commit_i.id)
    else $error("vfe_spec_buffer: commit id %0h out of order", commit_i.id);

endmodule

/* hw/vfe_dispatch.sv */
// Issue ready drops while the buffer is full or a kill is on the commit port.
// The back end sees committed entries only, in order, through a one-entry fall-through stage.
`timescale 1ns/100ps

module vfe_dispatch import vfe_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_i,
  input  vfe_issue_req_t  issue_req_i,
  input  vfe_commit_t     commit_i,
  input  vfe_class_t      class_i,
  input  logic            full_i,
  input  vfe_entry_t      head_i,
  input  logic            head_committed_i,
  input  logic            dispatch_ready_i,
  output vfe_issue_resp_t issue_resp_o,
  output logic            push_o,
  output logic            pop_o,
  output vfe_dispatch_t   dispatch_o
);

  logic       kill;
  logic       pass_through;
  logic       load;
  logic       reg_valid_q;
  vfe_entry_t reg_entry_q;

  assign kill = commit_i.valid && commit_i.kill;

  //////////////////////////////
  // Issue response
  //////////////////////////////

  always_comb begin
    issue_resp_o.ready         = issue_req_i.valid && !full_i && !kill;
    issue_resp_o.accept        = class_i.accept;
    issue_resp_o.writeback     = class_i.writeback;
    issue_resp_o.register_read = class_i.register_read;
  end

  // Rejected words finish the handshake but never enter the buffer
  assign push_o = issue_req_i.valid && issue_resp_o.ready && class_i.accept;

  //////////////////////////////
  // Fall-through register
  //////////////////////////////

  // Empty stage and ready back end, head goes straight out
  assign pass_through = !reg_valid_q && dispatch_ready_i;
  assign pop_o        = head_committed_i && (!reg_valid_q || dispatch_ready_i);
  assign load         = pop_o && !pass_through;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      reg_valid_q <= 1'b0;
    end else if (load) begin
      reg_valid_q <= 1'b1;
    end else if (dispatch_ready_i) begin
      reg_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      reg_entry_q <= head_i;
    end
  end

  assign dispatch_o.valid = reg_valid_q || head_committed_i;
  assign dispatch_o.entry = reg_valid_q ? reg_entry_q : head_i;

  // Offered entry is held across back-pressure, also while the buffer changes
  a_dispatch_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    dispatch_o.valid && !dispatch_ready_i |=> $stable(dispatch_o))
    else $error("vfe_dispatch: dispatch_o changed under back-pressure");

endmodule

/* hw/vfe_top.sv */
// Vector unit front end: classify, hold speculatively, dispatch on commit.
// Depth sets the number of in-flight accepted instructions.
`timescale 1ns/100ps

module vfe_top import vfe_pkg::*; #(
  parameter int unsigned Depth = 4
) (
  input  logic            clk_i,
  input  logic            rst_i,
  // Scalar core side
  input  vfe_issue_req_t  issue_req_i,
  output vfe_issue_resp_t issue_resp_o,
  input  vfe_commit_t     commit_i,
  // Back end side
  output vfe_dispatch_t   dispatch_o,
  input  logic            dispatch_ready_i
);

  vfe_class_t pd_class;
  vfe_entry_t buf_entry;
  vfe_entry_t buf_head;
  logic       buf_full;
  logic       buf_head_committed;
  logic       buf_push;
  logic       buf_pop;

  assign buf_entry = '{instr: issue_req_i.instr, id: issue_req_i.id};

  vfe_pre_decoder u_pre_decoder (
    .instr_i (issue_req_i.instr),
    .class_o (pd_class         )
  );

  vfe_spec_buffer #(
    .Depth (Depth)
  ) u_spec_buffer (
    .clk_i            (clk_i             ),
    .rst_i            (rst_i             ),
    .push_i           (buf_push          ),
    .entry_i          (buf_entry         ),
    .commit_i         (commit_i          ),
    .pop_i            (buf_pop           ),
    .full_o           (buf_full          ),
    .head_o           (buf_head          ),
    .head_committed_o (buf_head_committed)
  );

  vfe_dispatch u_dispatch (
    .clk_i            (clk_i             ),
    .rst_i            (rst_i             ),
    .issue_req_i      (issue_req_i       ),
    .commit_i         (commit_i          ),
    .class_i          (pd_class          ),
    .full_i           (buf_full          ),
    .head_i           (buf_head          ),
    .head_committed_i (buf_head_committed),
    .dispatch_ready_i (dispatch_ready_i  ),
    .issue_resp_o     (issue_resp_o      ),
    .push_o           (buf_push          ),
    .pop_o            (buf_pop           ),
    .dispatch_o       (dispatch_o        )
  );

endmodule

/* sim/tb_vfe_top.sv */
// Run from the project root, the stimulus file path is relative to it.
// Back-end ready is pseudo-random but repeatable, fixed by the LFSR seed.
`timescale 1ns/100ps

module tb_vfe_top import vfe_pkg::*; ();

  localparam int Depth = 4;

  logic            clk_i;
  logic            rst_i;
  vfe_issue_req_t  issue_req_i;
  vfe_issue_resp_t issue_resp_o;
  vfe_commit_t     commit_i;
  vfe_dispatch_t   dispatch_o;
  logic            dispatch_ready_i;

  // Stimulus loaded from the data file, one slot per I/C/K line
  byte                cmd_q[$];
  logic [31:0]        word_q[$];
  logic [IdWidth-1:0] id_q[$];
  logic [2:0]         cls_q[$];
  logic [31:0]        exp_instr_q[$];
  logic [IdWidth-1:0] exp_id_q[$];

  // Reference model of the buffer occupancy
  int          n_uncommitted = 0;
  int          n_commits     = 0;
  int          n_dispatched  = 0;
  int          stall_cycles  = 0;
  int          cycles        = 0;
  int          limit         = 0;
  logic [31:0] lfsr;

  vfe_top #(
    .Depth (Depth)
  ) u_vfe_top (
    .clk_i            (clk_i           ),
    .rst_i            (rst_i           ),
    .issue_req_i      (issue_req_i     ),
    .issue_resp_o     (issue_resp_o    ),
    .commit_i         (commit_i        ),
    .dispatch_o       (dispatch_o      ),
    .dispatch_ready_i (dispatch_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    end
  endtask

  // Galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  task automatic load_stimulus();
    int          fd;
    int          n;
    int          lines;
    byte         c;
    string       line;
    logic [31:0] w;
    logic [31:0] id;
    logic [31:0] a;
    logic [31:0] wb;
    logic [31:0] rr;
    lines = 0;
    fd = $fopen("sim/vfe_input.txt", "r");
    if (fd == 0) begin
      fail_run("Could not open the stimulus file sim/vfe_input.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        c = (line.len() > 0) ? line.getc(0) : "#";
        n = 0;
        if (c == "I") begin
          n = $sscanf(line, "I %h %h %h %h %h", w, id, a, wb, rr) - 4;
          word_q.push_back(w);
          cls_q.push_back({a[0], wb[0], rr[0]});
        end else if (c == "C") begin
          n = $sscanf(line, "C %h", id);
        end else if (c == "E") begin
          n = $sscanf(line, "E %h %h", w, id) - 1;
          exp_instr_q.push_back(w);
          exp_id_q.push_back(id[IdWidth-1:0]);
        end else if (c == "K") begin
          n = 1;
          id = '0;
        end
        if (c == "I" || c == "C" || c == "E" || c == "K") begin
          if (n != 1) begin
            fail_run($sformatf("Malformed stimulus line: %s", line));
          end
          lines++;
          if (c != "E") begin
            cmd_q.push_back(c);
            id_q.push_back(id[IdWidth-1:0]);
            if (c != "I") begin
              word_q.push_back('0);
              cls_q.push_back('0);
            end
          end
        end
      end
      $fclose(fd);
      limit = 20 * lines + 100;
    end
  endtask

  //////////////////////////////
  // Core-side drivers
  //////////////////////////////

  // Holds the request until the handshake, then checks the class
  task automatic issue_instr(input logic [31:0] word, input logic [IdWidth-1:0] id,
                             input logic [2:0] cls);
    bit done;
    int min_held;
    done = 1'b0;
    issue_req_i.valid = 1'b1;
    issue_req_i.instr = word;
    issue_req_i.id    = id;
    while (!done) begin
      @(negedge clk_i);
      // Fewer live entries than Depth, so the buffer cannot be full
      if (n_uncommitted + (n_commits - n_dispatched) < Depth) begin
        check_value("issue_resp_o.ready", 32'(issue_resp_o.ready), 32'd1);
      end
      // At most one committed entry sits outside the buffer
      min_held = n_uncommitted;
      if (n_commits - n_dispatched > 0) begin
        min_held = min_held + n_commits - n_dispatched - 1;
      end
      if (min_held >= Depth) begin
        check_value("issue_resp_o.ready", 32'(issue_resp_o.ready), 32'd0);
      end
      if (issue_resp_o.ready) begin
        check_value("issue_resp_o.accept", 32'(issue_resp_o.accept), 32'(cls[2]));
        check_value("issue_resp_o.writeback", 32'(issue_resp_o.writeback), 32'(cls[1]));
        check_value("issue_resp_o.register_read", 32'(issue_resp_o.register_read),
                    32'(cls[0]));
        if (cls[2]) begin
          n_uncommitted++;
        end
        done = 1'b1;
      end else begin
        stall_cycles++;
      end
      @(posedge clk_i);
      #2;
    end
    issue_req_i.valid = 1'b0;
  endtask

  task automatic send_commit(input logic [IdWidth-1:0] id, input bit kill);
    commit_i = '{valid: 1'b1, id: id, kill: kill};
    @(negedge clk_i);
    if (kill) begin
      n_uncommitted = 0;
    end else begin
      n_uncommitted--;
      n_commits++;
    end
    @(posedge clk_i);
    #2;
    commit_i = '0;
  endtask

  //////////////////////////////
  // Back end and checkers
  //////////////////////////////

  initial begin
    dispatch_ready_i = 1'b0;
    lfsr = 32'h3b21;
    forever begin
      @(posedge clk_i);
      #2;
      lfsr = lfsr_step(lfsr);
      dispatch_ready_i = lfsr[0];
    end
  end

  // Sampled just after the falling edge, away from the drive point
  initial begin
    forever begin
      @(negedge clk_i);
      #1;
      if (!rst_i && dispatch_o.valid && dispatch_ready_i) begin
        if (exp_instr_q.size() == 0) begin
          fail_run("An instruction was dispatched that the stimulus does not expect");
        end else if (n_commits == n_dispatched) begin
          fail_run("An instruction was dispatched before it was committed");
        end else begin
          check_value("dispatch_o.entry.instr", dispatch_o.entry.instr, exp_instr_q.pop_front());
          check_value("dispatch_o.entry.id", 32'(dispatch_o.entry.id), 32'(exp_id_q.pop_front()));
          n_dispatched++;
        end
      end
    end
  end

  initial begin
    forever begin
      @(posedge clk_i);
      cycles++;
      if (limit > 0 && cycles >= limit) begin
        fail_run($sformatf("The run timed out after %0d clock cycles", cycles));
      end
    end
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    rst_i       = 1'b1;
    issue_req_i = '0;
    commit_i    = '0;
    load_stimulus();
    repeat (4) @(posedge clk_i);
    #2;
    rst_i = 1'b0;
    @(negedge clk_i);
    check_value("dispatch_o.valid", 32'(dispatch_o.valid), 32'd0);
    @(posedge clk_i);
    #2;
    foreach (cmd_q[i]) begin
      case (cmd_q[i])
        "I": issue_instr(word_q[i], id_q[i], cls_q[i]);
        "C": send_commit(id_q[i], 1'b0);
        "K": send_commit('0, 1'b1);
        default: begin
        end
      endcase
    end
    // Drain every committed instruction to the back end
    while (n_dispatched != n_commits) @(posedge clk_i);
    $display("Issue waited on a full buffer for %0d cycles", stall_cycles);
    if (exp_instr_q.size() != 0) begin
      fail_run($sformatf("%0d expected dispatches never arrived", exp_instr_q.size()));
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

/* sim/vfe_input.txt */
# I instr id accept writeback register_read | C id | K (kill) | E instr id
# All fields in hex. E lines give the expected dispatch order.
I 022180D7 1 1 0 0
I 0221A0D7 2 1 0 0
I 422022D7 3 1 1 0
I 0222B0D7 4 1 0 0
C 1
C 2
C 3
C 4
I 0221C0D7 5 1 0 1
I 4201E0D7 6 1 0 1
I 0D0572D7 7 1 1 1
I 02056087 8 1 0 1
C 5
C 6
K
I 022190D7 C 0 0 0
I 02058127 9 1 0 1
I 0221D0D7 D 0 0 0
I 02065187 A 1 0 1
I 00052087 E 0 0 0
I 0206F207 B 1 0 1
I 0025B027 F 0 0 0
I 003100B3 0 0 0 0
C 9
C A
E 022180D7 1
E 0221A0D7 2
E 422022D7 3
E 0222B0D7 4
E 0221C0D7 5
E 4201E0D7 6
E 02058127 9
E 02065187 A

/* flist.f */
hw/vfe_pkg.sv
hw/vfe_pre_decoder.sv
hw/vfe_spec_buffer.sv
hw/vfe_dispatch.sv
hw/vfe_top.sv
sim/tb_vfe_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_vfe_top
FLIST     := flist.f
VFLAGS    := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FLIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
